// File: common/flash_pkg.sv
package flash_pkg;

    // opcodes used by the configuration sequence
    typedef enum logic [7:0] {
        WRITE_ENABLE   = 8'h06,
        WRITE_EXT_ADDR = 8'hC5, // one data byte follows the opcode
        READ           = 8'h03  // 24-bit address follows, then data
    } flash_opcode_e;

    localparam int FLASH_ADDR_W = 24;

    // with the extended address register at 1 these land in the upper 16 MB
    localparam logic [FLASH_ADDR_W-1:0] SYNC_FLASH_ADDR  = 24'h00_0000; // 0100_0000h
    localparam logic [FLASH_ADDR_W-1:0] ASYNC_FLASH_ADDR = 24'h2E_0000; // 012E_0000h

    // value written to the extended address register
    localparam logic [7:0] EXT_ADDR_HIGH = 8'h01;
    localparam logic [7:0] EXT_ADDR_LOW  = 8'h00;

    // command buffer
    localparam int WBUF_DEPTH  = 128;
    localparam int WBUF_ADDR_W = 7;
    localparam int WBUF_DATA_W = 32;
    localparam int WBUF_BIT_W  = 5;  // bit index inside one buffer word

    // transfer length, stored as number of bits minus one
    localparam int NBITS_W = 12;

    // bit counts of the commands the sequencer sends
    localparam logic [NBITS_W-1:0] WREN_NBITS     = 12'd7;
    localparam logic [NBITS_W-1:0] EXT_ADDR_NBITS = 12'd15;

    // image length in bits, must fit in NBITS_W
    localparam int BITSTREAM_BITS = 512;

endpackage

// File: common/chan_cfg_pkg.sv
package chan_cfg_pkg;

    localparam int N_CHAN = 5; // channel FPGAs sharing progb, cclk and din

    // program pulse, counted once initb is seen all low
    localparam int PROG_PULSE_CYCLES = 16;
    localparam int PULSE_CNT_W       = $clog2(PROG_PULSE_CYCLES);

    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        STORE_CMD1    = 4'd1,  // write enable
        LOAD1         = 4'd2,
        STORE_CMD2    = 4'd3,  // extended address = 1
        LOAD2         = 4'd4,
        STORE_CMD3    = 4'd5,  // read of the selected image
        START         = 4'd6,
        INIT1         = 4'd7,
        INIT2         = 4'd8,
        LOAD3         = 4'd9,
        WAIT_FOR_DONE = 4'd10,
        STORE_CMD4    = 4'd11, // write enable
        LOAD4         = 4'd12,
        STORE_CMD5    = 4'd13, // extended address = 0
        LOAD5         = 4'd14,
        DONE          = 4'd15
    } prog_state_e;

endpackage

// File: common/flash_cmd_if.sv
`timescale 1ns/1ps

interface flash_cmd_if;
    import flash_pkg::*;

    // sequencer side
    logic                   store_flash_command;
    logic [WBUF_ADDR_W-1:0] wbuf_address;
    logic [WBUF_DATA_W-1:0] flash_command;
    logic [NBITS_W-1:0]     flash_wr_nbits;  // bits to send minus one
    logic                   send_write_command;
    logic                   read_bitstream;
    logic                   prog_chan_in_progress;

    // flash side
    logic                   end_write_command;
    logic                   end_bitstream;
    logic                   bitstream;
    logic                   bitstream_valid;

    modport seq (
        output store_flash_command, wbuf_address, flash_command, flash_wr_nbits,
        output send_write_command, read_bitstream, prog_chan_in_progress,
        input  end_write_command, end_bitstream, bitstream, bitstream_valid
    );

    modport flash (
        input  store_flash_command, wbuf_address, flash_command, flash_wr_nbits,
        input  send_write_command, read_bitstream, prog_chan_in_progress,
        output end_write_command, end_bitstream, bitstream, bitstream_valid
    );

endinterface

// File: design/prog_channels/prog_channels.sv
`timescale 1ns/1ps

module prog_channels (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              async_mode,      // selects the async image
    input  logic                              prog_chan_start, // level, held until done
    input  logic [chan_cfg_pkg::N_CHAN-1:0]   initb,
    input  logic [chan_cfg_pkg::N_CHAN-1:0]   prog_done,
    output logic                              c_progb,
    output logic                              c_clk,
    output logic                              c_din,
    output logic                              prog_chan_done,
    output logic                              async_channels,  // image that was loaded
    output chan_cfg_pkg::prog_state_e         state,
    flash_cmd_if.seq                          cmd
);
    import flash_pkg::*;
    import chan_cfg_pkg::*;

    logic [N_CHAN-1:0]      initb_sync;
    logic [N_CHAN-1:0]      prog_done_sync;
    logic [PULSE_CNT_W-1:0] pulse_cnt;
    logic                   cclk_en;

    // where each command transfer hands over
    function automatic prog_state_e next_after_load(input prog_state_e cur);
        prog_state_e nxt;
        case (cur)
            LOAD1:   nxt = STORE_CMD2;
            LOAD2:   nxt = STORE_CMD3;
            LOAD4:   nxt = STORE_CMD5;
            default: nxt = DONE;
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        initb_sync     <= initb;
        prog_done_sync <= prog_done;
    end

    // data goes out one cycle behind the flash, the clock only on image bits
    always_ff @(posedge clk) begin
        c_din <= cmd.bitstream_valid ? cmd.bitstream : 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cclk_en <= 1'b0;
        end else begin
            cclk_en <= cmd.bitstream_valid;
        end
    end

    assign c_clk = cclk_en & ~clk; // rises mid-cycle, c_din is stable there

    always_ff @(posedge clk) begin
        if (reset) begin
            state                     <= IDLE;
            c_progb                   <= 1'b1;
            prog_chan_done            <= 1'b0;
            async_channels            <= 1'b0;
            pulse_cnt                 <= '0;
            cmd.store_flash_command   <= 1'b0;
            cmd.send_write_command    <= 1'b0;
            cmd.read_bitstream        <= 1'b0;
            cmd.prog_chan_in_progress <= 1'b0;
        end else begin
            cmd.store_flash_command <= 1'b0;
            cmd.wbuf_address        <= '0; // every command fits in word 0

            case (state)
                IDLE: begin
                    cmd.prog_chan_in_progress <= 1'b0;
                    if (prog_chan_start) begin
                        state <= STORE_CMD1;
                    end
                end

                STORE_CMD1: begin
                    cmd.prog_chan_in_progress <= 1'b1;
                    prog_chan_done            <= 1'b0;
                    cmd.store_flash_command   <= 1'b1;
                    cmd.flash_command         <= {WRITE_ENABLE, 24'h00_0000};
                    cmd.flash_wr_nbits        <= WREN_NBITS;
                    state                     <= LOAD1;
                end

                STORE_CMD2: begin
                    cmd.store_flash_command <= 1'b1;
                    cmd.flash_command       <= {WRITE_EXT_ADDR, EXT_ADDR_HIGH, 16'h0000};
                    cmd.flash_wr_nbits      <= EXT_ADDR_NBITS;
                    state                   <= LOAD2;
                end

                STORE_CMD3: begin
                    cmd.store_flash_command <= 1'b1;
                    if (async_mode) begin
                        cmd.flash_command <= {READ, ASYNC_FLASH_ADDR};
                    end else begin
                        cmd.flash_command <= {READ, SYNC_FLASH_ADDR};
                    end
                    c_progb <= 1'b0; // program pulse starts with START
                    state   <= START;
                end

                // command transfers, request held until the end pulse
                LOAD1, LOAD2, LOAD4, LOAD5: begin
                    cmd.send_write_command <= ~cmd.end_write_command;
                    if (cmd.end_write_command) begin
                        state <= next_after_load(state);
                    end
                end

                START: begin
                    pulse_cnt <= '0;
                    if (initb_sync == '0) begin // all channels cleared
                        state <= INIT1;
                    end
                end

                INIT1: begin
                    // keep progb low long enough for Tprogram
                    if (pulse_cnt == PULSE_CNT_W'(PROG_PULSE_CYCLES - 1)) begin
                        c_progb <= 1'b1;
                        state   <= INIT2;
                    end else begin
                        pulse_cnt <= pulse_cnt + 1'b1;
                    end
                end

                INIT2: begin
                    if (initb_sync == '1) begin // all channels ready for data
                        state <= LOAD3;
                    end
                end

                LOAD3: begin
                    cmd.read_bitstream <= ~cmd.end_bitstream;
                    if (cmd.end_bitstream) begin
                        state <= WAIT_FOR_DONE;
                    end
                end

                WAIT_FOR_DONE: begin
                    if (prog_done_sync == '1) begin
                        state <= STORE_CMD4;
                    end
                end

                STORE_CMD4: begin
                    cmd.store_flash_command <= 1'b1;
                    cmd.flash_command       <= {WRITE_ENABLE, 24'h00_0000};
                    cmd.flash_wr_nbits      <= WREN_NBITS;
                    state                   <= LOAD4;
                end

                STORE_CMD5: begin
                    // put the extended address back for the next reader of the flash
                    cmd.store_flash_command <= 1'b1;
                    cmd.flash_command       <= {WRITE_EXT_ADDR, EXT_ADDR_LOW, 16'h0000};
                    cmd.flash_wr_nbits      <= EXT_ADDR_NBITS;
                    state                   <= LOAD5;
                end

                DONE: begin
                    cmd.prog_chan_in_progress <= 1'b0;
                    prog_chan_done            <= 1'b1;
                    async_channels            <= async_mode;
                    if (!prog_chan_start) begin // wait for the start level to drop
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/spi_flash_intf/spi_flash_intf.sv
`timescale 1ns/1ps

module spi_flash_intf (
    input  logic        clk,
    input  logic        reset,
    input  logic        spi_miso,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    flash_cmd_if.flash  cmd
);
    import flash_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,   // opcode, address and data out on mosi
        READ,   // image bits in on miso
        FINISH
    } eng_state_e;

    eng_state_e             eng_state;
    logic [WBUF_DATA_W-1:0] wbuf [WBUF_DEPTH];
    logic [WBUF_DATA_W-1:0] next_word;
    logic [WBUF_DATA_W-1:0] shreg;
    logic [WBUF_ADDR_W-1:0] word_ptr;  // next word to load
    logic [NBITS_W-1:0]     bit_cnt;
    logic [NBITS_W-1:0]     last_bit;
    logic                   read_mode;
    logic                   write_q;
    logic                   read_q;
    logic                   write_rise;
    logic                   read_rise;

    always_ff @(posedge clk) begin
        if (cmd.store_flash_command && cmd.prog_chan_in_progress) begin
            wbuf[cmd.wbuf_address] <= cmd.flash_command;
        end
    end

    assign next_word = wbuf[word_ptr];

    // a request held high after its end pulse must not restart
    always_ff @(posedge clk) begin
        if (reset) begin
            write_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            write_q <= cmd.send_write_command;
            read_q  <= cmd.read_bitstream;
        end
    end

    assign write_rise = cmd.send_write_command & ~write_q & cmd.prog_chan_in_progress;
    assign read_rise  = cmd.read_bitstream & ~read_q & cmd.prog_chan_in_progress;

    assign spi_sck = ~clk & ~spi_cs_n; // flash samples mosi mid-cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            eng_state             <= IDLE;
            spi_cs_n              <= 1'b1;
            spi_mosi              <= 1'b0;
            word_ptr              <= '0;
            read_mode             <= 1'b0;
            cmd.end_write_command <= 1'b0;
            cmd.end_bitstream     <= 1'b0;
            cmd.bitstream_valid   <= 1'b0;
        end else begin
            cmd.end_write_command <= 1'b0;
            cmd.end_bitstream     <= 1'b0;
            cmd.bitstream_valid   <= 1'b0;

            case (eng_state)
                IDLE: begin
                    if (write_rise || read_rise) begin
                        eng_state <= SEND;
                        spi_cs_n  <= 1'b0;
                        read_mode <= read_rise;
                        // a read always sends the whole first word
                        last_bit  <= read_rise ? NBITS_W'(WBUF_DATA_W - 1) : cmd.flash_wr_nbits;
                        spi_mosi  <= next_word[WBUF_DATA_W-1];
                        shreg     <= {next_word[WBUF_DATA_W-2:0], 1'b0};
                        word_ptr  <= word_ptr + 1'b1;
                        bit_cnt   <= '0;
                    end
                end

                SEND: begin
                    if (bit_cnt == last_bit) begin
                        spi_mosi <= 1'b0;
                        bit_cnt  <= '0;
                        if (read_mode) begin
                            eng_state <= READ;
                        end else begin
                            eng_state             <= FINISH;
                            spi_cs_n              <= 1'b1;
                            cmd.end_write_command <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt[WBUF_BIT_W-1:0] == '1) begin // word boundary
                            spi_mosi <= next_word[WBUF_DATA_W-1];
                            shreg    <= {next_word[WBUF_DATA_W-2:0], 1'b0};
                            word_ptr <= word_ptr + 1'b1;
                        end else begin
                            spi_mosi <= shreg[WBUF_DATA_W-1];
                            shreg    <= {shreg[WBUF_DATA_W-2:0], 1'b0};
                        end
                    end
                end

                READ: begin
                    cmd.bitstream       <= spi_miso; // flash drove it after the falling sck
                    cmd.bitstream_valid <= 1'b1;
                    if (bit_cnt == NBITS_W'(BITSTREAM_BITS - 1)) begin
                        eng_state <= FINISH;
                        spi_cs_n  <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                FINISH: begin
                    // read end waits until the last image bit has been presented
                    cmd.end_bitstream <= read_mode;
                    word_ptr          <= '0;
                    eng_state         <= IDLE;
                end

                default: eng_state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/chan_config_top.sv
`timescale 1ns/1ps

module chan_config_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       async_mode,
    input  logic       prog_chan_start,
    input  logic [4:0] initb,
    input  logic [4:0] prog_done,
    input  logic       spi_miso,
    output logic       c_progb,
    output logic       c_clk,
    output logic       c_din,
    output logic       spi_cs_n,
    output logic       spi_sck,
    output logic       spi_mosi,
    output logic       prog_chan_done,
    output logic       async_channels,
    output logic [3:0] status    // sequencer state
);

    flash_cmd_if cmd ();

    prog_channels u_prog_channels (
        .clk             (clk),
        .reset           (reset),
        .async_mode      (async_mode),
        .prog_chan_start (prog_chan_start),
        .initb           (initb),
        .prog_done       (prog_done),
        .c_progb         (c_progb),
        .c_clk           (c_clk),
        .c_din           (c_din),
        .prog_chan_done  (prog_chan_done),
        .async_channels  (async_channels),
        .state           (status),
        .cmd             (cmd.seq)
    );

    spi_flash_intf u_spi_flash_intf (
        .clk      (clk),
        .reset    (reset),
        .spi_miso (spi_miso),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .cmd      (cmd.flash)
    );

endmodule

// File: dv/chan_config_checker.sv
`timescale 1ns/1ps

module chan_config_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic       async_mode,
    input  logic       prog_chan_start,
    input  logic [4:0] initb,
    input  logic [4:0] prog_done,
    input  logic       spi_miso,
    input  logic       spi_cs_n,
    input  logic       spi_sck,
    input  logic       spi_mosi,
    input  logic       c_progb,
    input  logic       c_clk,
    input  logic       c_din,
    input  logic       prog_chan_done,
    input  logic       async_channels,
    input  logic [3:0] status,
    output int         checks,
    output int         errors
);
    import flash_pkg::*;
    import chan_cfg_pkg::*;

    int          frame_bits = 0;
    logic [31:0] frame_head = '0;
    int          frame_idx = 0;     // position of the frame inside one run
    logic        wel = 1'b0;
    logic        closing_done = 1'b0;
    bit          exp_bits[$];       // image bits seen on miso, in order
    int          cclk_count = 0;
    int          low_cycles = 0;
    logic        init_ready = 1'b0;
    logic        progb_q = 1'b1;
    logic        done_q = 1'b0;
    prog_state_e state_q = IDLE;

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic flag(input string msg);
        checks++;
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic decode_frame();
        case (frame_idx)
            0, 3: begin
                compare("write enable length", 32'd8, frame_bits);
                compare("write enable opcode", 32'(WRITE_ENABLE), frame_head[7:0]);
                wel = 1'b1;
            end
            1, 4: begin
                compare("ext addr length", 32'd16, frame_bits);
                compare("ext addr opcode", 32'(WRITE_EXT_ADDR), frame_head[15:8]);
                compare("ext addr value", (frame_idx == 1) ? 32'h01 : 32'h00, frame_head[7:0]);
                if (!wel) begin
                    flag("extended address written without a write enable before it");
                end
                wel = 1'b0;
            end
            default: begin
                compare("read length", 32'(32 + BITSTREAM_BITS), frame_bits);
                compare("read opcode", 32'(READ), frame_head[31:24]);
                compare("read address", async_mode ? ASYNC_FLASH_ADDR : SYNC_FLASH_ADDR,
                        frame_head[23:0]);
            end
        endcase
        closing_done = (frame_idx == 4);
        frame_idx    = (frame_idx == 4) ? 0 : frame_idx + 1;
    endtask

    // mosi sampled at rising sck, miso is stable there too
    always @(posedge spi_sck) begin
        if (!reset) begin
            if (spi_cs_n) begin
                flag("spi_sck pulse while spi_cs_n was high");
            end else begin
                if (frame_bits < 32) begin
                    frame_head = {frame_head[30:0], spi_mosi};
                end else if (frame_head[31:24] == READ && frame_bits < 32 + BITSTREAM_BITS) begin
                    exp_bits.push_back(spi_miso);
                end
                frame_bits++;
            end
        end
    end

    always @(negedge spi_cs_n) begin
        if (!prog_chan_start) begin
            flag("SPI frame started while prog_chan_start was low");
        end
        frame_bits = 0;
        frame_head = '0;
        if (frame_idx == 2) begin // the image comes with this frame
            cclk_count = 0;
            exp_bits.delete();
        end
    end

    always @(posedge spi_cs_n) begin
        if (!reset && frame_bits > 0) begin
            decode_frame();
        end
    end

    always @(posedge c_clk) begin
        cclk_count++;
        if (!init_ready) begin
            flag("c_clk pulse before initb went all high");
        end
        if (exp_bits.size() == 0) begin
            flag("c_clk pulse without an image bit read from the flash");
        end else begin
            compare("c_din bit", exp_bits.pop_front(), c_din);
        end
    end

    // program pulse length and initb release
    always @(posedge clk) begin
        if (!reset) begin
            if (!c_progb) begin
                init_ready = 1'b0;
            end else if (initb == '1) begin
                init_ready = 1'b1;
            end
            if (progb_q && !c_progb) begin
                low_cycles = 0;
            end
            if (!c_progb && initb == '0) begin
                low_cycles++;
            end
            if (!progb_q && c_progb) begin
                checks++;
                if (low_cycles < PROG_PULSE_CYCLES) begin
                    errors++;
                    $display("[FAIL] program pulse: expected >= %0d, actual %0d",
                             PROG_PULSE_CYCLES, low_cycles);
                end
            end
        end
        progb_q = c_progb;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (prog_chan_done && !done_q) begin
                if (prog_done != '1) begin
                    flag("prog_chan_done rose before all prog_done lines were high");
                end
                if (!closing_done) begin
                    flag("prog_chan_done rose before the closing commands completed");
                end
                compare("async_channels", async_mode, async_channels);
                compare("c_clk pulse count", BITSTREAM_BITS, cclk_count);
            end
            if (state_q == DONE && status == DONE && !prog_chan_done) begin
                flag("prog_chan_done low while held in DONE");
            end
            if (state_q == STORE_CMD1 && status == LOAD1) begin
                compare("prog_chan_done after STORE_CMD1", 32'd0, prog_chan_done);
            end
        end
        done_q  = prog_chan_done;
        state_q = prog_state_e'(status);
    end

    always @(negedge reset) begin
        compare("c_progb after reset", 32'd1, c_progb);
        compare("spi_cs_n after reset", 32'd1, spi_cs_n);
        compare("prog_chan_done after reset", 32'd0, prog_chan_done);
        compare("status after reset", 32'd0, status);
    end

endmodule

// File: dv/tb_chan_config.sv
`timescale 1ns/1ps

module tb_chan_config;
    import flash_pkg::*;
    import chan_cfg_pkg::*;

    localparam int N_RUNS         = 6;
    localparam int RUN_CYCLES     = 700;                       // worst case per run
    localparam int TIMEOUT_CYCLES = N_RUNS * RUN_CYCLES + 800;

    logic              clk;
    logic              reset;
    logic              async_mode;
    logic              prog_chan_start;
    logic [N_CHAN-1:0] initb;
    logic [N_CHAN-1:0] prog_done;
    logic              spi_miso;
    logic              c_progb, c_clk, c_din;
    logic              spi_cs_n, spi_sck, spi_mosi;
    logic              prog_chan_done, async_channels;
    logic [3:0]        status;
    int                checks, errors;

    logic [31:0] seed;
    int          cycles = 0;
    int          fl_bits = 0;
    logic [31:0] fl_head = '0;
    logic        fl_wel = 1'b0;
    logic [7:0]  fl_ext = 8'h00;   // extended address register
    int          cclk_pulses = 0;
    int          seen_pulses = 0;
    logic        progb_q = 1'b1;
    int          low_cnt[N_CHAN];
    int          high_cnt[N_CHAN];
    int          done_cnt[N_CHAN];

    chan_config_top DUT (.*);

    chan_config_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int draw(input int lo, input int hi);
        seed = xorshift(seed);
        return lo + int'(seed % 32'(hi - lo + 1));
    endfunction

    // flash content, a hash of full address and bit index
    function automatic logic flash_bit(input logic [31:0] addr, input int idx);
        logic [31:0] h;
        h = xorshift(addr ^ (32'(idx) * 32'h9E37_79B9) ^ 32'h5BD1_E995);
        return h[16];
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // flash model
    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            if (fl_bits < 32) begin
                fl_head = {fl_head[30:0], spi_mosi};
            end
            fl_bits++;
        end
    end

    always @(negedge spi_cs_n) begin
        fl_bits = 0;
    end

    always @(posedge spi_cs_n) begin
        if (fl_bits == 8 && fl_head[7:0] == WRITE_ENABLE) begin
            fl_wel = 1'b1;
        end else if (fl_bits == 16 && fl_head[15:8] == WRITE_EXT_ADDR && fl_wel) begin
            fl_ext = fl_head[7:0];
            fl_wel = 1'b0;
        end
    end

    always @(negedge spi_sck) begin // miso moves after the falling sck
        if (!spi_cs_n && fl_bits >= 32 && fl_head[31:24] == READ) begin
            spi_miso <= flash_bit({fl_ext, fl_head[23:0]}, fl_bits - 32);
        end
    end

    // channel FPGA model
    always @(negedge c_clk) cclk_pulses++; // counted as each pulse ends

    always @(negedge clk) begin
        if (!reset) begin
            for (int ch = 0; ch < N_CHAN; ch++) begin
                if (progb_q && !c_progb) begin
                    low_cnt[ch]   = draw(1, 8);
                    done_cnt[ch]  = 0;
                    prog_done[ch] <= 1'b0;
                end else if (low_cnt[ch] > 0) begin
                    low_cnt[ch]--;
                    if (low_cnt[ch] == 0) initb[ch] <= 1'b0;
                end
                if (!progb_q && c_progb) begin
                    high_cnt[ch] = draw(1, 8);
                end else if (high_cnt[ch] > 0) begin
                    high_cnt[ch]--;
                    if (high_cnt[ch] == 0) initb[ch] <= 1'b1;
                end
                if (cclk_pulses != seen_pulses) begin
                    done_cnt[ch] = draw(2, 20); // restarts on every pulse
                end else if (done_cnt[ch] > 0) begin
                    done_cnt[ch]--;
                    if (done_cnt[ch] == 0) prog_done[ch] <= 1'b1;
                end
            end
        end
        progb_q     = c_progb;
        seen_pulses = cclk_pulses;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        seed            = 32'ha7d68a6c;
        reset           = 1'b1;
        async_mode      = 1'b0;
        prog_chan_start = 1'b0;
        initb           = '1;
        prog_done       = '0;
        spi_miso        = 1'b0;
        for (int ch = 0; ch < N_CHAN; ch++) begin
            low_cnt[ch]  = 0;
            high_cnt[ch] = 0;
            done_cnt[ch] = 0;
        end
        repeat (4) @(negedge clk);
        reset <= 1'b0;
        repeat (3) @(negedge clk);

        for (int run = 0; run < N_RUNS; run++) begin
            async_mode      <= 1'(draw(0, 1));
            prog_chan_start <= 1'b1;
            @(negedge clk);
            while (prog_chan_done) @(negedge clk); // done from the last run drops first
            while (!prog_chan_done) @(negedge clk);
            repeat (draw(1, 5)) @(negedge clk);
            prog_chan_start <= 1'b0;
            repeat (draw(2, 12)) @(negedge clk);
        end

        repeat (5) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
common/flash_pkg.sv
common/chan_cfg_pkg.sv
common/flash_cmd_if.sv
design/prog_channels/prog_channels.sv
design/spi_flash_intf/spi_flash_intf.sv
design/chan_config_top.sv
dv/chan_config_checker.sv
dv/tb_chan_config.sv

// File: Bender.yml
package:
  name: chan_config

sources:
  - common/flash_pkg.sv
  - common/chan_cfg_pkg.sv
  - common/flash_cmd_if.sv
  - design/prog_channels/prog_channels.sv
  - design/spi_flash_intf/spi_flash_intf.sv
  - design/chan_config_top.sv
  - target: test
    files:
      - dv/chan_config_checker.sv
      - dv/tb_chan_config.sv
